// ==== decode_defs.svh ====
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// widths fixed by the RV64 base ISA

// integer register, address and immediate width
`define XLEN_W 64

// one uncompressed instruction word
`define INSTR_W 32

// x0..x31
`define REG_IDX_W 5

`endif

// ==== rv_isa_pkg.sv ====
`include "decode_defs.svh"

package rv_isa_pkg;

  // raw word as fetched, all zero is a bubble
  typedef logic [`INSTR_W-1:0] instr_t;

  // program counter of the fetched word
  typedef logic [`XLEN_W-1:0] addr_t;

  // architectural register number
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;

  // major opcodes, bits 6:0 of the word
  // only the kept groups are listed, anything else decodes as illegal
  typedef enum logic [6:0] {
    OP_IMM    = 7'b0010011,
    OP_IMM_32 = 7'b0011011,
    OP_32     = 7'b0111011,
    LUI       = 7'b0110111,
    AUIPC     = 7'b0010111,
    JAL       = 7'b1101111,
    JALR      = 7'b1100111,
    BRANCH    = 7'b1100011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    SYSTEM    = 7'b1110011
  } opcode_e;

  // minor opcode, bits 14:12
  typedef logic [2:0] funct3_t;

  // R-type modifier, bits 31:25
  typedef logic [6:0] funct7_t;

endpackage

// ==== decode_ctrl_pkg.sv ====
`include "decode_defs.svh"

package decode_ctrl_pkg;

  // sign-extended immediate handed to execute
  typedef logic signed [`XLEN_W-1:0] data_t;

  // execute codes, numbering shared with the execute stage
  typedef enum logic [3:0] {
    NOP           = 4'd0,
    ADD           = 4'd1,
    SUB           = 4'd2,
    AND           = 4'd4,
    JUMP          = 4'd11,
    PC_ADD        = 4'd12,
    LOAD_REGISTER = 4'd13
  } ex_op_e;

  // branch condition, also tags the two jumps
  typedef enum logic [3:0] {
    BEQ  = 4'd0,
    BNE  = 4'd1,
    BLT  = 4'd2,
    BGE  = 4'd3,
    BLTU = 4'd4,
    BGEU = 4'd5,
    JAL  = 4'd6,
    JALR = 4'd7
  } branch_e;

  // what the memory stage does with this instruction
  typedef enum logic [6:0] {
    MEM_SYS   = 7'd0,
    MEM_LOAD  = 7'd1,
    MEM_STORE = 7'd2,
    MEM_NONE  = 7'd3
  } mem_op_e;

  // access width, unsigned variants zero-extend on load
  typedef enum logic [3:0] {
    DOUBLE_WORD        = 4'd0,
    WORD               = 4'd1,
    HALF_WORD          = 4'd2,
    BYTE               = 4'd3,
    UNSIGNED_WORD      = 4'd4,
    UNSIGNED_HALF_WORD = 4'd5,
    UNSIGNED_BYTE      = 4'd6
  } mem_size_e;

  // immediate layout, IMM_NONE means no immediate
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

  // second ALU operand source
  typedef enum logic {
    SEL_REG2 = 1'b0,
    SEL_IMM  = 1'b1
  } operand_sel_e;

endpackage

// ==== fetch_slot.sv ====
`timescale 1ns/1ps

module fetch_slot (
  input  logic               clk,
  input  logic               rst,
  input  rv_isa_pkg::instr_t instruction,
  input  rv_isa_pkg::addr_t  instruction_pc,
  input  logic               next_stage_ready,
  output logic               ready,
  output rv_isa_pkg::instr_t slot_instr,
  output rv_isa_pkg::addr_t  slot_pc
);

  // a zero word is a bubble and can always be taken
  // otherwise fetch waits on execute
  assign ready = (instruction == '0) || next_stage_ready;

  // input slot, first of the two items in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      // empty slot decodes as a bubble
      slot_instr <= '0;
      slot_pc    <= '0;
    end else if (next_stage_ready) begin
      slot_instr <= instruction;
      slot_pc    <= instruction_pc;
    end
    // hold on back-pressure, fetch keeps its word stable too
  end

endmodule

// ==== ctrl_decode.sv ====
`timescale 1ns/1ps

module ctrl_decode (
  input  rv_isa_pkg::instr_t            slot_instr,
  output decode_ctrl_pkg::ex_op_e       ex_opcode,
  output decode_ctrl_pkg::branch_e      branch_type,
  output rv_isa_pkg::reg_idx_t          r1_reg,
  output rv_isa_pkg::reg_idx_t          r2_reg,
  output rv_isa_pkg::reg_idx_t          dst_reg,
  output logic                          is_word_op,
  output decode_ctrl_pkg::operand_sel_e imm_or_reg2,
  output decode_ctrl_pkg::mem_op_e      mem_opcode,
  output decode_ctrl_pkg::mem_size_e    mem_operation_size,
  output logic                          ecall,
  output decode_ctrl_pkg::imm_fmt_e     imm_fmt
);

  rv_isa_pkg::opcode_e  opcode;
  rv_isa_pkg::funct3_t  funct3;
  rv_isa_pkg::funct7_t  funct7;
  rv_isa_pkg::reg_idx_t rd;
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rs2;
  logic                 legal;

  // field positions are the same in every base format
  assign opcode = rv_isa_pkg::opcode_e'(slot_instr[6:0]);
  assign rd     = slot_instr[11:7];
  assign funct3 = slot_instr[14:12];
  assign rs1    = slot_instr[19:15];
  assign rs2    = slot_instr[24:20];
  assign funct7 = slot_instr[31:25];

  always_comb begin
    // start from the bubble decode
    legal              = 1'b0;
    ex_opcode          = decode_ctrl_pkg::NOP;
    branch_type        = decode_ctrl_pkg::branch_e'(0);
    r1_reg             = '0;
    r2_reg             = '0;
    dst_reg            = '0;
    is_word_op         = 1'b0;
    imm_or_reg2        = decode_ctrl_pkg::SEL_REG2;
    mem_opcode         = decode_ctrl_pkg::mem_op_e'(0);
    mem_operation_size = decode_ctrl_pkg::mem_size_e'(0);
    ecall              = 1'b0;
    imm_fmt            = decode_ctrl_pkg::IMM_NONE;

    case (opcode)
      rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM_32: begin
        // ADDI, ANDI and ADDIW, the word form only has funct3 000
        legal = (funct3 == 3'b000) || (funct3 == 3'b111 && opcode == rv_isa_pkg::OP_IMM);
        ex_opcode   = (funct3 == 3'b111) ? decode_ctrl_pkg::AND : decode_ctrl_pkg::ADD;
        is_word_op  = (opcode == rv_isa_pkg::OP_IMM_32);
        dst_reg     = rd;
        r1_reg      = rs1;
        imm_or_reg2 = decode_ctrl_pkg::SEL_IMM;
        mem_opcode  = decode_ctrl_pkg::MEM_NONE;
        imm_fmt     = decode_ctrl_pkg::IMM_I;
      end

      rv_isa_pkg::OP_32: begin
        // ADDW and SUBW only
        legal = (funct3 == 3'b000) && (funct7 == 7'b0000000 || funct7 == 7'b0100000);
        ex_opcode  = funct7[5] ? decode_ctrl_pkg::SUB : decode_ctrl_pkg::ADD;
        is_word_op = 1'b1;
        dst_reg    = rd;
        r1_reg     = rs1;
        r2_reg     = rs2;
        mem_opcode = decode_ctrl_pkg::MEM_NONE;
      end

      rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: begin
        legal = 1'b1;
        // LUI just passes the immediate through, AUIPC adds the pc
        ex_opcode   = (opcode == rv_isa_pkg::LUI) ? decode_ctrl_pkg::LOAD_REGISTER
                                                  : decode_ctrl_pkg::PC_ADD;
        dst_reg     = rd;
        imm_or_reg2 = decode_ctrl_pkg::SEL_IMM;
        mem_opcode  = decode_ctrl_pkg::MEM_NONE;
        imm_fmt     = decode_ctrl_pkg::IMM_U;
      end

      rv_isa_pkg::JAL: begin
        legal       = 1'b1;
        ex_opcode   = decode_ctrl_pkg::JUMP;
        branch_type = decode_ctrl_pkg::JAL;
        dst_reg     = rd;
        imm_or_reg2 = decode_ctrl_pkg::SEL_IMM;
        mem_opcode  = decode_ctrl_pkg::MEM_NONE;
        imm_fmt     = decode_ctrl_pkg::IMM_J;
      end

      rv_isa_pkg::JALR: begin
        // target is rs1 plus I immediate
        legal       = 1'b1;
        ex_opcode   = decode_ctrl_pkg::JUMP;
        branch_type = decode_ctrl_pkg::JALR;
        dst_reg     = rd;
        r1_reg      = rs1;
        imm_or_reg2 = decode_ctrl_pkg::SEL_IMM;
        mem_opcode  = decode_ctrl_pkg::MEM_NONE;
        imm_fmt     = decode_ctrl_pkg::IMM_I;
      end

      rv_isa_pkg::BRANCH: begin
        legal = 1'b1;
        case (funct3)
          3'b000:  branch_type = decode_ctrl_pkg::BEQ;
          3'b001:  branch_type = decode_ctrl_pkg::BNE;
          3'b100:  branch_type = decode_ctrl_pkg::BLT;
          3'b101:  branch_type = decode_ctrl_pkg::BGE;
          3'b110:  branch_type = decode_ctrl_pkg::BLTU;
          3'b111:  branch_type = decode_ctrl_pkg::BGEU;
          // 010 and 011 are reserved
          default: legal = 1'b0;
        endcase
        // compare uses both registers, offset comes via imm
        ex_opcode  = decode_ctrl_pkg::JUMP;
        r1_reg     = rs1;
        r2_reg     = rs2;
        mem_opcode = decode_ctrl_pkg::MEM_NONE;
        imm_fmt    = decode_ctrl_pkg::IMM_B;
      end

      rv_isa_pkg::LOAD: begin
        legal = 1'b1;
        case (funct3)
          3'b000:  mem_operation_size = decode_ctrl_pkg::BYTE;
          3'b001:  mem_operation_size = decode_ctrl_pkg::HALF_WORD;
          3'b010:  mem_operation_size = decode_ctrl_pkg::WORD;
          3'b011:  mem_operation_size = decode_ctrl_pkg::DOUBLE_WORD;
          3'b100:  mem_operation_size = decode_ctrl_pkg::UNSIGNED_BYTE;
          3'b101:  mem_operation_size = decode_ctrl_pkg::UNSIGNED_HALF_WORD;
          3'b110:  mem_operation_size = decode_ctrl_pkg::UNSIGNED_WORD;
          default: legal = 1'b0;
        endcase
        // address is rs1 plus offset, computed by execute
        ex_opcode   = decode_ctrl_pkg::ADD;
        dst_reg     = rd;
        r1_reg      = rs1;
        imm_or_reg2 = decode_ctrl_pkg::SEL_IMM;
        mem_opcode  = decode_ctrl_pkg::MEM_LOAD;
        imm_fmt     = decode_ctrl_pkg::IMM_I;
      end

      rv_isa_pkg::STORE: begin
        legal = 1'b1;
        case (funct3)
          3'b000:  mem_operation_size = decode_ctrl_pkg::BYTE;
          3'b001:  mem_operation_size = decode_ctrl_pkg::HALF_WORD;
          3'b010:  mem_operation_size = decode_ctrl_pkg::WORD;
          3'b011:  mem_operation_size = decode_ctrl_pkg::DOUBLE_WORD;
          default: legal = 1'b0;
        endcase
        // rs2 is the store data, no destination
        ex_opcode   = decode_ctrl_pkg::ADD;
        r1_reg      = rs1;
        r2_reg      = rs2;
        imm_or_reg2 = decode_ctrl_pkg::SEL_IMM;
        mem_opcode  = decode_ctrl_pkg::MEM_STORE;
        imm_fmt     = decode_ctrl_pkg::IMM_S;
      end

      rv_isa_pkg::SYSTEM: begin
        // ECALL is the one fully zero SYSTEM word
        legal      = (slot_instr[31:7] == '0);
        ecall      = 1'b1;
        mem_opcode = decode_ctrl_pkg::MEM_SYS;
      end

      default: legal = 1'b0;
    endcase

    // unsupported encodings fall back to the bubble
    if (!legal) begin
      ex_opcode          = decode_ctrl_pkg::NOP;
      branch_type        = decode_ctrl_pkg::branch_e'(0);
      r1_reg             = '0;
      r2_reg             = '0;
      dst_reg            = '0;
      is_word_op         = 1'b0;
      imm_or_reg2        = decode_ctrl_pkg::SEL_REG2;
      mem_opcode         = decode_ctrl_pkg::mem_op_e'(0);
      mem_operation_size = decode_ctrl_pkg::mem_size_e'(0);
      ecall              = 1'b0;
      imm_fmt            = decode_ctrl_pkg::IMM_NONE;
    end
  end

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
  input  rv_isa_pkg::instr_t        slot_instr,
  input  decode_ctrl_pkg::imm_fmt_e imm_fmt,
  output decode_ctrl_pkg::data_t    imm_value
);

  always_comb begin
    case (imm_fmt)
      // bits 31:20, loads, JALR and the ALU immediates
      decode_ctrl_pkg::IMM_I: begin
        imm_value = decode_ctrl_pkg::data_t'($signed(slot_instr[31:20]));
      end

      // stores split the offset around rs2
      decode_ctrl_pkg::IMM_S: begin
        imm_value = decode_ctrl_pkg::data_t'($signed({slot_instr[31:25],
                                                      slot_instr[11:7]}));
      end

      // branch offset in halfwords, bit 0 always zero
      decode_ctrl_pkg::IMM_B: begin
        imm_value = decode_ctrl_pkg::data_t'($signed({slot_instr[31], slot_instr[7],
                                                      slot_instr[30:25],
                                                      slot_instr[11:8], 1'b0}));
      end

      // upper 20 bits, zero-extended and not shifted
      // execute does the shift by 12
      decode_ctrl_pkg::IMM_U: begin
        imm_value = decode_ctrl_pkg::data_t'(slot_instr[31:12]);
      end

      // JAL offset, 21 bits with bit 0 zero
      decode_ctrl_pkg::IMM_J: begin
        imm_value = decode_ctrl_pkg::data_t'($signed({slot_instr[31], slot_instr[19:12],
                                                      slot_instr[20], slot_instr[30:21],
                                                      1'b0}));
      end

      // R-type, ECALL and bubbles carry no immediate
      default: imm_value = '0;
    endcase
  end

endmodule

// ==== decode_out_reg.sv ====
`timescale 1ns/1ps

module decode_out_reg (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          next_stage_ready,
  input  decode_ctrl_pkg::ex_op_e       dec_ex_opcode,
  input  decode_ctrl_pkg::branch_e      dec_branch_type,
  input  rv_isa_pkg::reg_idx_t          dec_r1_reg,
  input  rv_isa_pkg::reg_idx_t          dec_r2_reg,
  input  rv_isa_pkg::reg_idx_t          dec_dst_reg,
  input  logic                          dec_is_word_op,
  input  decode_ctrl_pkg::operand_sel_e dec_imm_or_reg2,
  input  decode_ctrl_pkg::mem_op_e      dec_mem_opcode,
  input  decode_ctrl_pkg::mem_size_e    dec_mem_operation_size,
  input  logic                          dec_ecall,
  input  decode_ctrl_pkg::data_t        imm_value,
  input  rv_isa_pkg::addr_t             slot_pc,
  output rv_isa_pkg::addr_t             next_stage_pc,
  output decode_ctrl_pkg::ex_op_e       ex_opcode,
  output decode_ctrl_pkg::branch_e      branch_type,
  output rv_isa_pkg::reg_idx_t          r1_reg,
  output rv_isa_pkg::reg_idx_t          r2_reg,
  output rv_isa_pkg::reg_idx_t          dst_reg,
  output decode_ctrl_pkg::data_t        imm,
  output logic                          is_word_op,
  output decode_ctrl_pkg::operand_sel_e imm_or_reg2,
  output decode_ctrl_pkg::mem_op_e      mem_opcode,
  output decode_ctrl_pkg::mem_size_e    mem_operation_size,
  output logic                          ecall
);

  // second item in flight, the bundle execute sees
  always_ff @(posedge clk) begin
    if (rst) begin
      // all zero is the bubble decode, ecall included
      next_stage_pc      <= '0;
      ex_opcode          <= decode_ctrl_pkg::NOP;
      branch_type        <= decode_ctrl_pkg::branch_e'(0);
      r1_reg             <= '0;
      r2_reg             <= '0;
      dst_reg            <= '0;
      imm                <= '0;
      is_word_op         <= 1'b0;
      imm_or_reg2        <= decode_ctrl_pkg::SEL_REG2;
      mem_opcode         <= decode_ctrl_pkg::mem_op_e'(0);
      mem_operation_size <= decode_ctrl_pkg::mem_size_e'(0);
      ecall              <= 1'b0;
    end else if (next_stage_ready) begin
      // advance together with the input slot
      next_stage_pc      <= slot_pc;
      ex_opcode          <= dec_ex_opcode;
      branch_type        <= dec_branch_type;
      r1_reg             <= dec_r1_reg;
      r2_reg             <= dec_r2_reg;
      dst_reg            <= dec_dst_reg;
      imm                <= imm_value;
      is_word_op         <= dec_is_word_op;
      imm_or_reg2        <= dec_imm_or_reg2;
      mem_opcode         <= dec_mem_opcode;
      mem_operation_size <= dec_mem_operation_size;
      ecall              <= dec_ecall;
    end
  end

endmodule

// ==== pipeline_decode.sv ====
`timescale 1ns/1ps

module pipeline_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  rv_isa_pkg::instr_t            instruction,
  input  rv_isa_pkg::addr_t             instruction_pc,
  input  logic                          next_stage_ready,
  output logic                          ready,
  output rv_isa_pkg::addr_t             next_stage_pc,
  output decode_ctrl_pkg::ex_op_e       ex_opcode,
  output decode_ctrl_pkg::branch_e      branch_type,
  output rv_isa_pkg::reg_idx_t          r1_reg,
  output rv_isa_pkg::reg_idx_t          r2_reg,
  output rv_isa_pkg::reg_idx_t          dst_reg,
  output decode_ctrl_pkg::data_t        imm,
  output logic                          is_word_op,
  output decode_ctrl_pkg::operand_sel_e imm_or_reg2,
  output decode_ctrl_pkg::mem_op_e      mem_opcode,
  output decode_ctrl_pkg::mem_size_e    mem_operation_size,
  output logic                          ecall
);

  // input slot to decode
  rv_isa_pkg::instr_t            slot_instr;
  rv_isa_pkg::addr_t             slot_pc;

  // combinational decode, before the output register
  decode_ctrl_pkg::ex_op_e       dec_ex_opcode;
  decode_ctrl_pkg::branch_e      dec_branch_type;
  rv_isa_pkg::reg_idx_t          dec_r1_reg;
  rv_isa_pkg::reg_idx_t          dec_r2_reg;
  rv_isa_pkg::reg_idx_t          dec_dst_reg;
  logic                          dec_is_word_op;
  decode_ctrl_pkg::operand_sel_e dec_imm_or_reg2;
  decode_ctrl_pkg::mem_op_e      dec_mem_opcode;
  decode_ctrl_pkg::mem_size_e    dec_mem_operation_size;
  logic                          dec_ecall;
  decode_ctrl_pkg::imm_fmt_e     imm_fmt;
  decode_ctrl_pkg::data_t        imm_value;

  fetch_slot u_fetch_slot (
    .clk              (clk),
    .rst              (rst),
    .instruction      (instruction),
    .instruction_pc   (instruction_pc),
    .next_stage_ready (next_stage_ready),
    .ready            (ready),
    .slot_instr       (slot_instr),
    .slot_pc          (slot_pc)
  );

  ctrl_decode u_ctrl_decode (
    .slot_instr         (slot_instr),
    .ex_opcode          (dec_ex_opcode),
    .branch_type        (dec_branch_type),
    .r1_reg             (dec_r1_reg),
    .r2_reg             (dec_r2_reg),
    .dst_reg            (dec_dst_reg),
    .is_word_op         (dec_is_word_op),
    .imm_or_reg2        (dec_imm_or_reg2),
    .mem_opcode         (dec_mem_opcode),
    .mem_operation_size (dec_mem_operation_size),
    .ecall              (dec_ecall),
    .imm_fmt            (imm_fmt)
  );

  imm_gen u_imm_gen (
    .slot_instr (slot_instr),
    .imm_fmt    (imm_fmt),
    .imm_value  (imm_value)
  );

  decode_out_reg u_decode_out_reg (
    .clk                    (clk),
    .rst                    (rst),
    .next_stage_ready       (next_stage_ready),
    .dec_ex_opcode          (dec_ex_opcode),
    .dec_branch_type        (dec_branch_type),
    .dec_r1_reg             (dec_r1_reg),
    .dec_r2_reg             (dec_r2_reg),
    .dec_dst_reg            (dec_dst_reg),
    .dec_is_word_op         (dec_is_word_op),
    .dec_imm_or_reg2        (dec_imm_or_reg2),
    .dec_mem_opcode         (dec_mem_opcode),
    .dec_mem_operation_size (dec_mem_operation_size),
    .dec_ecall              (dec_ecall),
    .imm_value              (imm_value),
    .slot_pc                (slot_pc),
    .next_stage_pc          (next_stage_pc),
    .ex_opcode              (ex_opcode),
    .branch_type            (branch_type),
    .r1_reg                 (r1_reg),
    .r2_reg                 (r2_reg),
    .dst_reg                (dst_reg),
    .imm                    (imm),
    .is_word_op             (is_word_op),
    .imm_or_reg2            (imm_or_reg2),
    .mem_opcode             (mem_opcode),
    .mem_operation_size     (mem_operation_size),
    .ecall                  (ecall)
  );

endmodule

// ==== tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// one field per DUT output, compared as a whole
typedef struct packed {
  logic [63:0] pc;
  logic [3:0]  ex_op;
  logic [3:0]  br;
  logic [4:0]  r1;
  logic [4:0]  r2;
  logic [4:0]  rd;
  logic [63:0] imm;
  logic        word;
  logic        sel;
  logic [6:0]  mem_op;
  logic [3:0]  size;
  logic        ecall;
} dec_exp_t;

// execute codes of the execute stage
localparam logic [3:0] X_ADD   = 4'd1;
localparam logic [3:0] X_SUB   = 4'd2;
localparam logic [3:0] X_AND   = 4'd4;
localparam logic [3:0] X_JUMP  = 4'd11;
localparam logic [3:0] X_PCADD = 4'd12;
localparam logic [3:0] X_LDREG = 4'd13;

// memory stage codes
localparam logic [6:0] M_SYS   = 7'd0;
localparam logic [6:0] M_LOAD  = 7'd1;
localparam logic [6:0] M_STORE = 7'd2;
localparam logic [6:0] M_NONE  = 7'd3;

// expected decode of one word, the pc rides along unchanged
function automatic dec_exp_t decode_ref(input logic [31:0] w, input logic [63:0] pc);
  dec_exp_t    d;
  logic        ok;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_b;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  f3 = w[14:12];
  f7 = w[31:25];
  imm_i = {{52{w[31]}}, w[31:20]};
  imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
  imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  // U stays in place, upper bits zero
  imm_u = {44'd0, w[31:12]};
  imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  d  = '0;
  ok = 1'b1;
  case (w[6:0])
    7'b0010011, 7'b0011011: begin
      // addi, andi, addiw
      ok = (f3 == 3'b000) || (f3 == 3'b111 && w[3] == 1'b0);
      d.ex_op = (f3 == 3'b111) ? X_AND : X_ADD;
      d.word  = w[3];
      d.rd    = w[11:7];
      d.r1    = w[19:15];
      d.sel   = 1'b1;
      d.imm   = imm_i;
      d.mem_op = M_NONE;
    end
    7'b0111011: begin
      // addw, subw
      ok = (f3 == 3'b000) && (f7 == 7'h00 || f7 == 7'h20);
      d.ex_op  = (f7 == 7'h20) ? X_SUB : X_ADD;
      d.word   = 1'b1;
      d.rd     = w[11:7];
      d.r1     = w[19:15];
      d.r2     = w[24:20];
      d.mem_op = M_NONE;
    end
    7'b0110111, 7'b0010111: begin
      // lui has bit 5 set, auipc not
      d.ex_op  = w[5] ? X_LDREG : X_PCADD;
      d.rd     = w[11:7];
      d.sel    = 1'b1;
      d.imm    = imm_u;
      d.mem_op = M_NONE;
    end
    7'b1101111: begin
      d.ex_op  = X_JUMP;
      d.br     = 4'd6;
      d.rd     = w[11:7];
      d.sel    = 1'b1;
      d.imm    = imm_j;
      d.mem_op = M_NONE;
    end
    7'b1100111: begin
      d.ex_op  = X_JUMP;
      d.br     = 4'd7;
      d.rd     = w[11:7];
      d.r1     = w[19:15];
      d.sel    = 1'b1;
      d.imm    = imm_i;
      d.mem_op = M_NONE;
    end
    7'b1100011: begin
      // 000 001 map to 0 1, 100..111 map to 2..5
      ok = (f3 != 3'b010) && (f3 != 3'b011);
      d.br     = f3[2] ? {1'b0, f3} - 4'd2 : {1'b0, f3};
      d.ex_op  = X_JUMP;
      d.r1     = w[19:15];
      d.r2     = w[24:20];
      d.imm    = imm_b;
      d.mem_op = M_NONE;
    end
    7'b0000011: begin
      // signed sizes count down from byte, unsigned from 6
      ok = (f3 != 3'b111);
      d.size   = f3[2] ? 4'd10 - {1'b0, f3} : 4'd3 - {1'b0, f3};
      d.ex_op  = X_ADD;
      d.rd     = w[11:7];
      d.r1     = w[19:15];
      d.sel    = 1'b1;
      d.imm    = imm_i;
      d.mem_op = M_LOAD;
    end
    7'b0100011: begin
      ok = (f3[2] == 1'b0);
      d.size   = 4'd3 - {2'b00, f3[1:0]};
      d.ex_op  = X_ADD;
      d.r1     = w[19:15];
      d.r2     = w[24:20];
      d.sel    = 1'b1;
      d.imm    = imm_s;
      d.mem_op = M_STORE;
    end
    7'b1110011: begin
      // only the bare ecall word
      ok = (w[31:7] == 25'd0);
      d.ecall  = 1'b1;
      d.mem_op = M_SYS;
    end
    default: ok = 1'b0;
  endcase
  if (!ok) begin
    d = '0;
  end
  d.pc = pc;
  return d;
endfunction

`endif

// ==== tb_pipeline_decode.sv ====
`timescale 1ns/1ps

module tb_pipeline_decode;

  // length of the run in vectors, bounds the watchdog
  localparam int     N_FIXED     = 64;
  localparam int     N_RANDOM    = 300;
  localparam int     N_STALL     = 120;
  localparam int     N_VEC       = N_FIXED + N_RANDOM + N_STALL;
  localparam longint WATCHDOG_NS = (longint'(N_VEC) * 4 + 200) * 20;

  logic                          clk;
  logic                          rst;
  rv_isa_pkg::instr_t            instruction;
  rv_isa_pkg::addr_t             instruction_pc;
  logic                          next_stage_ready;
  logic                          ready;
  rv_isa_pkg::addr_t             next_stage_pc;
  decode_ctrl_pkg::ex_op_e       ex_opcode;
  decode_ctrl_pkg::branch_e      branch_type;
  rv_isa_pkg::reg_idx_t          r1_reg;
  rv_isa_pkg::reg_idx_t          r2_reg;
  rv_isa_pkg::reg_idx_t          dst_reg;
  decode_ctrl_pkg::data_t        imm;
  logic                          is_word_op;
  decode_ctrl_pkg::operand_sel_e imm_or_reg2;
  decode_ctrl_pkg::mem_op_e      mem_opcode;
  decode_ctrl_pkg::mem_size_e    mem_operation_size;
  logic                          ecall;

  `include "tb_ref_model.svh"

  // expected pipe, pipe1 is what the outputs show
  dec_exp_t    pipe0;
  dec_exp_t    pipe1;
  dec_exp_t    prev_out;
  bit          started;
  bit          held_last;
  // ready as the stimulus expects it
  bit          exp_ready = 1'b1;
  int          err_count;
  int          check_count;
  logic [31:0] lcg_state = 32'd38;
  logic [63:0] cur_pc = 64'h0000_0000_8000_0000;

  pipeline_decode uut (
    .clk                (clk),
    .rst                (rst),
    .instruction        (instruction),
    .instruction_pc     (instruction_pc),
    .next_stage_ready   (next_stage_ready),
    .ready              (ready),
    .next_stage_pc      (next_stage_pc),
    .ex_opcode          (ex_opcode),
    .branch_type        (branch_type),
    .r1_reg             (r1_reg),
    .r2_reg             (r2_reg),
    .dst_reg            (dst_reg),
    .imm                (imm),
    .is_word_op         (is_word_op),
    .imm_or_reg2        (imm_or_reg2),
    .mem_opcode         (mem_opcode),
    .mem_operation_size (mem_operation_size),
    .ecall              (ecall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // kept opcode with random upper bits, some ecall words mixed in
  function automatic logic [31:0] random_word();
    logic [31:0] r;
    logic [31:0] s;
    logic [6:0]  opc;
    r = lcg_next();
    s = lcg_next();
    case (s[31:16] % 16'd11)
      16'd0:   opc = 7'b0010011;
      16'd1:   opc = 7'b0011011;
      16'd2:   opc = 7'b0111011;
      16'd3:   opc = 7'b0110111;
      16'd4:   opc = 7'b0010111;
      16'd5:   opc = 7'b1101111;
      16'd6:   opc = 7'b1100111;
      16'd7:   opc = 7'b1100011;
      16'd8:   opc = 7'b0000011;
      16'd9:   opc = 7'b0100011;
      default: opc = 7'b1110011;
    endcase
    if (opc == 7'b1110011 && s[15]) begin
      return 32'h0000_0073;
    end
    return {r[31:7], opc};
  endfunction

  function automatic dec_exp_t current_outputs();
    dec_exp_t d;
    d.pc     = next_stage_pc;
    d.ex_op  = ex_opcode;
    d.br     = branch_type;
    d.r1     = r1_reg;
    d.r2     = r2_reg;
    d.rd     = dst_reg;
    d.imm    = imm;
    d.word   = is_word_op;
    d.sel    = imm_or_reg2;
    d.mem_op = mem_opcode;
    d.size   = mem_operation_size;
    d.ecall  = ecall;
    return d;
  endfunction

  task automatic check_field(input string name, input logic [63:0] e, input logic [63:0] a);
    check_count++;
    assert (e === a) else begin
      $display("error: %s expected %h actual %h at %0t", name, e, a, $time);
      err_count++;
    end
  endtask

  task automatic compare_all(input dec_exp_t e, input dec_exp_t a);
    check_field("next_stage_pc", e.pc, a.pc);
    check_field("ex_opcode", 64'(e.ex_op), 64'(a.ex_op));
    check_field("branch_type", 64'(e.br), 64'(a.br));
    check_field("r1_reg", 64'(e.r1), 64'(a.r1));
    check_field("r2_reg", 64'(e.r2), 64'(a.r2));
    check_field("dst_reg", 64'(e.rd), 64'(a.rd));
    check_field("imm", e.imm, a.imm);
    check_field("is_word_op", 64'(e.word), 64'(a.word));
    check_field("imm_or_reg2", 64'(e.sel), 64'(a.sel));
    check_field("mem_opcode", 64'(e.mem_op), 64'(a.mem_op));
    check_field("mem_operation_size", 64'(e.size), 64'(a.size));
    check_field("ecall", 64'(e.ecall), 64'(a.ecall));
  endtask

  // model side, sees the inputs as they were before the edge
  always @(posedge clk) begin
    started = 1'b1;
    held_last = !rst && !next_stage_ready;
    if (rst) begin
      pipe0 = '0;
      pipe1 = '0;
    end else if (next_stage_ready) begin
      pipe1 = pipe0;
      pipe0 = decode_ref(instruction, instruction_pc);
    end
  end

  // compare mid-cycle, everything settled
  always @(negedge clk) begin
    if (started) begin
      compare_all(pipe1, current_outputs());
      check_field("ready", 64'(exp_ready), 64'(ready));
      if (held_last) begin
        check_count++;
        assert (current_outputs() === prev_out) else begin
          $display("outputs changed on an edge where next_stage_ready was low at %0t", $time);
          err_count++;
        end
      end
      prev_out = current_outputs();
    end
  end

  // apply one word, optionally stall first, return after the consuming edge
  // a bubble in a stalled stream always waits
  task automatic push(input logic [31:0] w, input bit stall);
    int          hold;
    logic [31:0] r;
    hold = 0;
    if (stall) begin
      r = lcg_next();
      if (r[31:30] == 2'b00 || w == 32'd0) begin
        hold = 1 + int'(r[29:16]) % 5;
      end
    end
    instruction    <= w;
    instruction_pc <= cur_pc;
    cur_pc = cur_pc + 64'd4;
    repeat (hold) begin
      next_stage_ready <= 1'b0;
      // only a bubble is taken while execute stalls
      exp_ready = (w == 32'd0);
      @(posedge clk);
    end
    next_stage_ready <= 1'b1;
    exp_ready = 1'b1;
    @(posedge clk);
  endtask

  // two bubbles push the last real word out to the compare
  task automatic flush();
    push(32'd0, 1'b0);
    push(32'd0, 1'b0);
  endtask

  task automatic end_test(input string name, input int e0, input int c0);
    $display("test %s: %0d checks, %0d errors", name, check_count - c0, err_count - e0);
  endtask

  task automatic run_directed();
    logic [31:0] words [14];
    // listing words, then addw, two jal and ecall
    words = '{32'hfe010113, 32'h00113c23, 32'h000007b7, 32'h00000317, 32'h000300e7,
              32'h0207d463, 32'h0ff7f713, 32'h40f704bb, 32'hfff7871b, 32'h0007c783,
              32'h002081bb, 32'h008000ef, 32'hffdff06f, 32'h00000073};
    foreach (words[i]) begin
      push(words[i], 1'b0);
    end
    // all branch, load and store funct3 values
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        push(32'h00208063 | (32'(f) << 12), 1'b0);
      end
    end
    for (int f = 0; f < 7; f++) begin
      push(32'h00830283 | (32'(f) << 12), 1'b0);
    end
    for (int f = 0; f < 4; f++) begin
      push(32'hfe208e23 | (32'(f) << 12), 1'b0);
    end
    flush();
  endtask

  task automatic run_illegal();
    // mulw, ori, branch 010, store 100, unknown opcode
    push(32'h022081bb, 1'b0);
    push(32'h00136293, 1'b0);
    push(32'h0020a063, 1'b0);
    push(32'hfe20ce23, 1'b0);
    push(32'h0000007f, 1'b0);
    flush();
  endtask

  initial begin
    int e0;
    int c0;
    rst              <= 1'b1;
    instruction      <= '0;
    instruction_pc   <= '0;
    next_stage_ready <= 1'b1;

    // reset held over 3 edges, checked one edge beyond
    e0 = err_count;
    c0 = check_count;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      if (i == 2) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      compare_all('0, current_outputs());
      check_field("ready", 64'd1, 64'(ready));
    end
    @(posedge clk);
    end_test("reset", e0, c0);

    e0 = err_count;
    c0 = check_count;
    run_directed();
    end_test("directed", e0, c0);

    e0 = err_count;
    c0 = check_count;
    run_illegal();
    end_test("illegal", e0, c0);

    e0 = err_count;
    c0 = check_count;
    for (int i = 0; i < N_RANDOM; i++) begin
      push(random_word(), 1'b0);
    end
    flush();
    end_test("random", e0, c0);

    // same stream kind with random stalls, every eighth word a bubble
    e0 = err_count;
    c0 = check_count;
    for (int i = 0; i < N_STALL; i++) begin
      if (i % 8 == 7) begin
        push(32'd0, 1'b1);
      end else begin
        push(random_word(), 1'b1);
      end
    end
    flush();
    @(negedge clk);
    end_test("backpressure", e0, c0);

    $display("summary: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
rv_isa_pkg.sv
decode_ctrl_pkg.sv
fetch_slot.sv
ctrl_decode.sv
imm_gen.sv
decode_out_reg.sv
pipeline_decode.sv
tb_pipeline_decode.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_pipeline_decode -o sim_pipeline_decode

./obj_dir/sim_pipeline_decode | tee sim.log

if grep -q "=== PASS ===" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
